// File: verilog/carrierPkg.sv
package carrierPkg;

    // demodulation mode codes with code 7 unused
    localparam logic [2:0] MODE_AM    = 3'd0;
    localparam logic [2:0] MODE_PM    = 3'd1;
    localparam logic [2:0] MODE_FM    = 3'd2;
    localparam logic [2:0] MODE_2FSK  = 3'd3;
    localparam logic [2:0] MODE_BPSK  = 3'd4;
    localparam logic [2:0] MODE_QPSK  = 3'd5;
    localparam logic [2:0] MODE_OQPSK = 3'd6;

    // matched against addr[11:4]
    localparam logic [7:0] CARRIER_SPACE = 8'h24;

    // word selects from addr[3:2]
    localparam logic [1:0] REG_CTRL  = 2'd0;  // bit0 invert, bit1 zero, bit2 sweep
    localparam logic [1:0] REG_GAIN  = 2'd1;
    localparam logic [1:0] REG_LIMIT = 2'd2;
    localparam logic [1:0] REG_SWEEP = 2'd3;

    localparam int ERROR_WIDTH = 8;   // Q1.7
    localparam int ACCUM_WIDTH = 32;

    // field view of the gain register
    typedef struct packed {
        logic [18:0] reservedHi;
        logic [4:0]  lagExp;      // bits 12:8
        logic [2:0]  reservedLo;
        logic [4:0]  leadExp;     // bits 4:0
    } gainFields_t;

    // The gain register is written a byte at a time on the bus side and read
    // as exponent fields on the loop side.
    typedef union packed {
        logic [3:0][7:0] bytes;
        gainFields_t     fields;
    } gainWord_u;

endpackage

// File: verilog/loopRegs.sv
module loopRegs (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [11:0]           addr,
    input  logic [31:0]           din,
    input  logic                  wr0,
    input  logic                  wr1,
    input  logic                  wr2,
    input  logic                  wr3,
    output logic [31:0]           dout,
    output logic                  invertError,
    output logic                  zeroError,
    output logic                  sweepEnable,
    output carrierPkg::gainWord_u gainWord,
    output logic [31:0]           limit,
    output logic [31:0]           sweepStep
);

    logic                  inSpace;
    logic [1:0]            regSel;
    logic [3:0]            wrLane;
    logic [31:0]           ctrlReg;
    carrierPkg::gainWord_u gainReg;
    logic [31:0]           limitReg;
    logic [31:0]           sweepReg;

    assign inSpace = (addr[11:4] == carrierPkg::CARRIER_SPACE);
    assign regSel  = addr[3:2];
    assign wrLane  = {wr3, wr2, wr1, wr0};  // lane 0 is din[7:0]

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlReg  <= '0;
            gainReg  <= '0;
            limitReg <= '0;
            sweepReg <= '0;
        end else if (inSpace) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wrLane[lane]) begin
                    case (regSel)
                        carrierPkg::REG_CTRL:  ctrlReg[lane*8 +: 8]  <= din[lane*8 +: 8];
                        carrierPkg::REG_GAIN:  gainReg.bytes[lane]   <= din[lane*8 +: 8];
                        carrierPkg::REG_LIMIT: limitReg[lane*8 +: 8] <= din[lane*8 +: 8];
                        default:               sweepReg[lane*8 +: 8] <= din[lane*8 +: 8];
                    endcase
                end
            end
        end
    end

    // readback of the addressed word
    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (regSel)
                carrierPkg::REG_CTRL:  dout = ctrlReg;
                carrierPkg::REG_GAIN:  dout = gainReg.bytes;
                carrierPkg::REG_LIMIT: dout = limitReg;
                default:               dout = sweepReg;
            endcase
        end
    end

    assign invertError = ctrlReg[0];
    assign zeroError   = ctrlReg[1];
    assign sweepEnable = ctrlReg[2];
    assign gainWord    = gainReg;
    assign limit       = limitReg;   // integrator bound magnitude
    assign sweepStep   = sweepReg;   // sweep increment magnitude

endmodule

// File: verilog/errorSelect.sv
module errorSelect (
    input  logic       clk,
    input  logic       reset,
    input  logic [2:0] demodMode,
    input  logic [7:0] phase,
    input  logic [7:0] freq,
    input  logic [7:0] offsetError,
    input  logic       offsetErrorEn,
    input  logic       ddcSync,
    input  logic       resampSync,
    input  logic       invertError,
    input  logic       zeroError,
    output logic [7:0] loopError,
    output logic       errorValid
);

    logic [7:0] modeError;
    logic       modeSync;
    logic       modeEn;
    logic       rawStrobe;
    logic [7:0] adjError;

    // pick error source, timing strobe and enable per mode
    always_comb begin
        modeError = 8'h00;
        modeSync  = ddcSync;
        modeEn    = 1'b1;
        case (demodMode)
            carrierPkg::MODE_AM: begin
                modeError = 8'h00;
            end
            carrierPkg::MODE_PM: begin
                modeError = phase;
            end
            carrierPkg::MODE_FM: begin
                modeError = freq;
            end
            carrierPkg::MODE_2FSK: begin
                modeError = offsetError;
                modeSync  = resampSync;   // symbol rate pacing
                modeEn    = offsetErrorEn;
            end
            carrierPkg::MODE_BPSK: begin
                modeError = {phase[6:0], 1'b0};  // 2x strips the modulation
            end
            carrierPkg::MODE_QPSK,
            carrierPkg::MODE_OQPSK: begin
                modeError = {phase[5:0], 2'b00} - 8'h20;  // 4x minus 45 degrees
            end
            default: begin
                modeError = 8'h00;
                modeSync  = 1'b1;         // free running
            end
        endcase
    end

    assign rawStrobe = modeSync & modeEn;

    // zero wins over invert
    always_comb begin
        if (zeroError) begin
            adjError = 8'h00;
        end else if (invertError) begin
            adjError = ~modeError + 8'd1;  // wraps at 0x80
        end else begin
            adjError = modeError;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            loopError  <= '0;
            errorValid <= 1'b0;
        end else begin
            errorValid <= rawStrobe;
            if (rawStrobe) begin
                loopError <= adjError;  // held between samples
            end
        end
    end

endmodule

// File: verilog/leadGain.sv
module leadGain (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               errorValid,
    input  logic [carrierPkg::ERROR_WIDTH-1:0] loopError,
    input  logic [4:0]                         leadExp,
    output logic [carrierPkg::ACCUM_WIDTH-1:0] leadError
);

    localparam int PAD = carrierPkg::ACCUM_WIDTH - carrierPkg::ERROR_WIDTH;

    logic signed [carrierPkg::ACCUM_WIDTH-1:0] errorWord;
    logic signed [carrierPkg::ACCUM_WIDTH-1:0] scaled;

    // error into the top byte as e * 2^24
    assign errorWord = $signed({loopError, {PAD{1'b0}}});

    // proportional gain is 2^-leadExp
    assign scaled = errorWord >>> leadExp;

    always_ff @(posedge clk) begin
        if (reset) begin
            leadError <= '0;
        end else if (errorValid) begin
            leadError <= scaled;
        end
    end

endmodule

// File: verilog/lagGain.sv
module lagGain (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               errorValid,
    input  logic [carrierPkg::ERROR_WIDTH-1:0] loopError,
    input  logic [4:0]                         lagExp,
    input  logic [carrierPkg::ACCUM_WIDTH-1:0] limit,
    input  logic                               sweepEnable,
    input  logic [carrierPkg::ACCUM_WIDTH-1:0] sweepStep,
    output logic [carrierPkg::ACCUM_WIDTH-1:0] lagAccum
);

    localparam int AW  = carrierPkg::ACCUM_WIDTH;
    localparam int XW  = AW + 2;   // headroom for overshoot detection
    localparam int PAD = AW - carrierPkg::ERROR_WIDTH;

    logic signed [AW-1:0] errorWord;
    logic signed [AW-1:0] errorScaled;
    logic signed [XW-1:0] errorExt;
    logic signed [XW-1:0] accumExt;
    logic signed [XW-1:0] stepExt;
    logic signed [XW-1:0] posLim;
    logic signed [XW-1:0] negLim;
    logic signed [XW-1:0] sum;
    logic [AW-1:0]        nextAccum;
    logic                 nextDown;
    logic                 dirDown;      // sweep direction with 0 as up

    assign errorWord   = $signed({loopError, {PAD{1'b0}}});
    assign errorScaled = errorWord >>> lagExp;

    assign errorExt = {{2{errorScaled[AW-1]}}, errorScaled};
    assign accumExt = {{2{lagAccum[AW-1]}}, lagAccum};
    assign posLim   = $signed({2'b00, limit});
    assign negLim   = -posLim;

    // sweep steps toward the current direction
    assign stepExt = dirDown ? -$signed({2'b00, sweepStep}) : $signed({2'b00, sweepStep});

    always_comb begin
        sum       = accumExt + (sweepEnable ? stepExt : errorExt);
        nextAccum = sum[AW-1:0];
        nextDown  = dirDown;
        if (sum > posLim) begin
            nextAccum = posLim[AW-1:0];
            nextDown  = ~dirDown;       // bounce off the top
        end else if (sum < negLim) begin
            nextAccum = negLim[AW-1:0];
            nextDown  = ~dirDown;       // bounce off the bottom
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum <= '0;
            dirDown  <= 1'b0;
        end else begin
            if (errorValid) begin
                lagAccum <= nextAccum;
            end
            if (!sweepEnable) begin
                dirDown <= 1'b0;        // next sweep starts upward
            end else if (errorValid) begin
                dirDown <= nextDown;
            end
        end
    end

endmodule

// File: verilog/loopFilter.sv
module loopFilter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               errorValid,
    input  logic [carrierPkg::ERROR_WIDTH-1:0] loopError,
    input  logic [4:0]                         leadExp,
    input  logic [4:0]                         lagExp,
    input  logic [carrierPkg::ACCUM_WIDTH-1:0] limit,
    input  logic                               sweepEnable,
    input  logic [carrierPkg::ACCUM_WIDTH-1:0] sweepStep,
    output logic [carrierPkg::ACCUM_WIDTH-1:0] freqOffset,
    output logic                               freqEn
);

    logic [carrierPkg::ACCUM_WIDTH-1:0] leadError;
    logic [carrierPkg::ACCUM_WIDTH-1:0] lagAccum;
    logic                               sumLoad;

    leadGain u_leadGain (
        .clk        (clk),
        .reset      (reset),
        .errorValid (errorValid),
        .loopError  (loopError),
        .leadExp    (leadExp),
        .leadError  (leadError)
    );

    lagGain u_lagGain (
        .clk         (clk),
        .reset       (reset),
        .errorValid  (errorValid),
        .loopError   (loopError),
        .lagExp      (lagExp),
        .limit       (limit),
        .sweepEnable (sweepEnable),
        .sweepStep   (sweepStep),
        .lagAccum    (lagAccum)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            sumLoad    <= 1'b0;
            freqOffset <= '0;
            freqEn     <= 1'b0;
        end else begin
            sumLoad <= errorValid;      // gain registers just loaded
            freqEn  <= sumLoad;         // pulses with the new sum
            if (sumLoad) begin
                freqOffset <= lagAccum + leadError;
            end
        end
    end

endmodule

// File: verilog/carrierLoop.sv
module carrierLoop (
    input  logic        clk,
    input  logic        reset,
    input  logic        ddcSync,
    input  logic        resampSync,
    input  logic        wr0,
    input  logic        wr1,
    input  logic        wr2,
    input  logic        wr3,
    input  logic [11:0] addr,
    input  logic [31:0] din,
    output logic [31:0] dout,
    input  logic [2:0]  demodMode,
    input  logic [7:0]  phase,
    input  logic [7:0]  freq,
    input  logic [7:0]  offsetError,
    input  logic        offsetErrorEn,
    output logic [31:0] carrierFreqOffset,
    output logic        carrierFreqEn
);

    logic                  invertError;
    logic                  zeroError;
    logic                  sweepEnable;
    carrierPkg::gainWord_u gainWord;
    logic [4:0]            leadExp;
    logic [4:0]            lagExp;
    logic [31:0]           limit;
    logic [31:0]           sweepStep;
    logic [7:0]            loopError;
    logic                  errorValid;

    loopRegs u_loopRegs (
        .clk         (clk),
        .reset       (reset),
        .addr        (addr),
        .din         (din),
        .wr0         (wr0),
        .wr1         (wr1),
        .wr2         (wr2),
        .wr3         (wr3),
        .dout        (dout),
        .invertError (invertError),
        .zeroError   (zeroError),
        .sweepEnable (sweepEnable),
        .gainWord    (gainWord),
        .limit       (limit),
        .sweepStep   (sweepStep)
    );

    // exponent fields out of the gain word
    assign leadExp = gainWord.fields.leadExp;
    assign lagExp  = gainWord.fields.lagExp;

    errorSelect u_errorSelect (
        .clk           (clk),
        .reset         (reset),
        .demodMode     (demodMode),
        .phase         (phase),
        .freq          (freq),
        .offsetError   (offsetError),
        .offsetErrorEn (offsetErrorEn),
        .ddcSync       (ddcSync),
        .resampSync    (resampSync),
        .invertError   (invertError),
        .zeroError     (zeroError),
        .loopError     (loopError),
        .errorValid    (errorValid)
    );

    loopFilter u_loopFilter (
        .clk         (clk),
        .reset       (reset),
        .errorValid  (errorValid),
        .loopError   (loopError),
        .leadExp     (leadExp),
        .lagExp      (lagExp),
        .limit       (limit),
        .sweepEnable (sweepEnable),
        .sweepStep   (sweepStep),
        .freqOffset  (carrierFreqOffset),
        .freqEn      (carrierFreqEn)
    );

endmodule

// File: tests/carrierLoopTb.sv
module carrierLoopTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES   = 16;
    localparam int SAMPLE_CYCLES = 8;
    localparam int SETUP_CYCLES  = 13;   // four writes, idle, drain
    localparam int BUS_CYCLES    = 40;   // reset plus register bus test
    localparam int CYCLE_LIMIT   = NUM_ENTRIES * (SAMPLE_CYCLES + SETUP_CYCLES)
                                   + BUS_CYCLES + 100;
    localparam logic [2:0] MODE_UNUSED = 3'd7;

    typedef struct packed {
        logic [2:0]  mode;
        logic [7:0]  phase;
        logic [7:0]  freq;
        logic [7:0]  offsetError;
        logic [7:0]  offEnPat;    // one bit per sample cycle
        logic [7:0]  ddcPat;
        logic [7:0]  resampPat;
        logic [2:0]  ctrl;        // sweep, zero, invert
        logic [4:0]  leadExp;
        logic [4:0]  lagExp;
        logic [31:0] limit;
        logic [31:0] sweepStep;
    } stimEntry_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        ddcSync;
    logic        resampSync;
    logic [3:0]  wrLanes;
    logic [11:0] addr;
    logic [31:0] din;
    logic [31:0] dout;
    logic [2:0]  demodMode;
    logic [7:0]  phase;
    logic [7:0]  freq;
    logic [7:0]  offsetError;
    logic        offsetErrorEn;
    logic [31:0] carrierFreqOffset;
    logic        carrierFreqEn;

    stimEntry_t  stimTable[NUM_ENTRIES];
    string       names[NUM_ENTRIES];
    string       currentName = "reset";
    int          entryCount = 0;
    int          seed = 18016;
    int          errors = 0;
    int          checks = 0;
    int          cycleCount = 0;
    int          pulseCount = 0;
    logic [31:0] expQ[$];               // predicted offsets in order
    longint      lagModel = 0;
    logic        dirModel = 1'b0;       // 1 is sweeping down

    carrierLoop u_carrierLoop (
        .clk               (clk),
        .reset             (reset),
        .ddcSync           (ddcSync),
        .resampSync        (resampSync),
        .wr0               (wrLanes[0]),
        .wr1               (wrLanes[1]),
        .wr2               (wrLanes[2]),
        .wr3               (wrLanes[3]),
        .addr              (addr),
        .din               (din),
        .dout              (dout),
        .demodMode         (demodMode),
        .phase             (phase),
        .freq              (freq),
        .offsetError       (offsetError),
        .offsetErrorEn     (offsetErrorEn),
        .carrierFreqOffset (carrierFreqOffset),
        .carrierFreqEn     (carrierFreqEn)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the run did not finish", cycleCount);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // every update pulse is matched against the oldest prediction
    always @(negedge clk) begin
        if (!reset && carrierFreqEn) begin
            pulseCount++;
            if (expQ.size() == 0) begin
                errors++;
                $display("%s: carrierFreqEn pulsed when no update was expected", currentName);
            end else begin
                checkValue(currentName, expQ.pop_front(), carrierFreqOffset);
            end
        end
    end

    function automatic logic [11:0] regAddr(input logic [1:0] offset);
        return {carrierPkg::CARRIER_SPACE, offset, 2'b00};
    endfunction

    function automatic logic [7:0] expectedError(input stimEntry_t ent);
        logic [7:0] e;
        case (ent.mode)
            carrierPkg::MODE_PM:    e = ent.phase;
            carrierPkg::MODE_FM:    e = ent.freq;
            carrierPkg::MODE_2FSK:  e = ent.offsetError;
            carrierPkg::MODE_BPSK:  e = ent.phase * 8'd2;
            carrierPkg::MODE_QPSK,
            carrierPkg::MODE_OQPSK: e = ent.phase * 8'd4 - 8'h20;
            default:                e = 8'h00;   // AM and the unused code
        endcase
        if (ent.ctrl[1]) begin
            e = 8'h00;
        end else if (ent.ctrl[0]) begin
            e = 8'h00 - e;
        end
        return e;
    endfunction

    function automatic logic expectedStrobe(input stimEntry_t ent, input int k);
        if (ent.mode == carrierPkg::MODE_2FSK) begin
            return ent.resampPat[k] & ent.offEnPat[k];
        end else if (ent.mode == MODE_UNUSED) begin
            return 1'b1;
        end
        return ent.ddcPat[k];
    endfunction

    // lead/lag model working in 64-bit signed integers
    task automatic modelSample(input stimEntry_t ent);
        logic signed [7:0] errSigned;
        longint            errWord;
        longint            lead;
        longint            inc;
        longint            sum;
        longint            lim;
        longint            step;
        logic [31:0]       offset;
        errSigned = expectedError(ent);
        errWord   = errSigned;
        errWord   = errWord * 16777216;   // error in the top byte
        lim       = ent.limit;
        step      = ent.sweepStep;
        lead      = errWord >>> ent.leadExp;
        if (ent.ctrl[2]) begin
            inc = dirModel ? -step : step;
        end else begin
            inc = errWord >>> ent.lagExp;
        end
        sum = lagModel + inc;
        if (sum > lim) begin
            lagModel = lim;
            if (ent.ctrl[2]) begin
                dirModel = ~dirModel;   // sweep reverses at the bound
            end
        end else if (sum < -lim) begin
            lagModel = -lim;
            if (ent.ctrl[2]) begin
                dirModel = ~dirModel;
            end
        end else begin
            lagModel = sum;
        end
        offset = lagModel + lead;
        expQ.push_back(offset);
    endtask

    task automatic addEntry(input string name, input logic [2:0] mode,
                            input logic [7:0] offEnPat, input logic [7:0] ddcPat,
                            input logic [7:0] resampPat, input logic [2:0] ctrl,
                            input logic [4:0] leadExp, input logic [4:0] lagExp,
                            input logic [31:0] limit, input logic [31:0] sweepStep);
        stimEntry_t ent;
        ent.mode        = mode;
        ent.phase       = $random(seed);
        ent.freq        = $random(seed);
        ent.offsetError = $random(seed);
        ent.offEnPat    = offEnPat;
        ent.ddcPat      = ddcPat;
        ent.resampPat   = resampPat;
        ent.ctrl        = ctrl;
        ent.leadExp     = leadExp;
        ent.lagExp      = lagExp;
        ent.limit       = limit;
        ent.sweepStep   = sweepStep;
        names[entryCount]     = name;
        stimTable[entryCount] = ent;
        entryCount++;
    endtask

    task automatic buildTable();
        // name, mode, offEn, ddc, resamp, ctrl, lead, lag, limit, step
        addEntry("am", carrierPkg::MODE_AM, 8'h00, 8'hB5, 8'h00, 0, 0, 0, 0, 0);
        addEntry("pm", carrierPkg::MODE_PM, 8'h00, 8'hFF, 8'h00, 0, 0, 0, 0, 0);
        addEntry("fm", carrierPkg::MODE_FM, 8'h00, 8'h55, 8'h00, 0, 0, 0, 0, 0);
        addEntry("2fsk", carrierPkg::MODE_2FSK, 8'hAA, 8'hFF, 8'hCC, 0, 0, 0, 0, 0);
        addEntry("bpsk", carrierPkg::MODE_BPSK, 8'h00, 8'h7E, 8'h00, 0, 0, 0, 0, 0);
        addEntry("qpsk", carrierPkg::MODE_QPSK, 8'h00, 8'hFF, 8'h00, 0, 0, 0, 0, 0);
        addEntry("oqpsk", carrierPkg::MODE_OQPSK, 8'h00, 8'h3C, 8'h00, 0, 0, 0, 0, 0);
        addEntry("code 7", MODE_UNUSED, 8'h00, 8'h00, 8'h00, 0, 0, 0, 0, 0);
        addEntry("invert", carrierPkg::MODE_PM, 8'h00, 8'hFF, 8'h00, 1, 0, 0, 0, 0);
        addEntry("zero", carrierPkg::MODE_FM, 8'h00, 8'hFF, 8'h00, 2, 0, 0, 0, 0);
        addEntry("zero wins", carrierPkg::MODE_PM, 8'h00, 8'hFF, 8'h00, 3, 0, 0, 0, 0);
        addEntry("integrate", carrierPkg::MODE_PM, 8'h00, 8'hFF, 8'h00, 0, 2, 6,
                 32'h0300_0000, 0);
        addEntry("clamp", carrierPkg::MODE_FM, 8'h00, 8'hFF, 8'h00, 0, 1, 2,
                 32'h0800_0000, 0);
        addEntry("sweep", carrierPkg::MODE_AM, 8'h00, 8'hFF, 8'h00, 4, 0, 0,
                 32'h0000_0500, 32'h0000_0180);
        addEntry("sweep gated", carrierPkg::MODE_PM, 8'h00, 8'hEE, 8'h00, 4, 3, 0,
                 32'h0400_0000, 32'h0180_0000);
        addEntry("leave sweep", carrierPkg::MODE_2FSK, 8'h6F, 8'h00, 8'hFF, 0, 4, 8,
                 32'h1000_0000, 0);
    endtask

    task automatic driveIdle();
        demodMode     = carrierPkg::MODE_AM;
        phase         = 8'h00;
        freq          = 8'h00;
        offsetError   = 8'h00;
        offsetErrorEn = 1'b0;
        ddcSync       = 1'b0;
        resampSync    = 1'b0;
    endtask

    task automatic busWrite(input logic [11:0] a, input logic [31:0] data,
                            input logic [3:0] lanes);
        @(negedge clk);
        addr    = a;
        din     = data;
        wrLanes = lanes;
        @(negedge clk);
        wrLanes = 4'b0000;
    endtask

    task automatic readCheck(input string name, input logic [11:0] a,
                             input logic [31:0] expected);
        @(negedge clk);
        addr = a;
        #1;
        checkValue(name, expected, dout);
    endtask

    task automatic busTest();
        logic [11:0] outside;
        outside = {8'h25, carrierPkg::REG_LIMIT, 2'b00};   // neighbouring block
        busWrite(regAddr(carrierPkg::REG_LIMIT), 32'h1122_3344, 4'hF);
        readCheck("limit full write", regAddr(carrierPkg::REG_LIMIT), 32'h1122_3344);
        busWrite(regAddr(carrierPkg::REG_LIMIT), 32'hAABB_CCDD, 4'b0010);
        readCheck("limit lane 1", regAddr(carrierPkg::REG_LIMIT), 32'h1122_CC44);
        busWrite(regAddr(carrierPkg::REG_LIMIT), 32'h5500_0000, 4'b1000);
        readCheck("limit lane 3", regAddr(carrierPkg::REG_LIMIT), 32'h5522_CC44);
        busWrite(regAddr(carrierPkg::REG_SWEEP), 32'hDEAD_BEEF, 4'hF);
        busWrite(regAddr(carrierPkg::REG_SWEEP), 32'h0000_0012, 4'b0001);
        readCheck("sweep lane 0", regAddr(carrierPkg::REG_SWEEP), 32'hDEAD_BE12);
        busWrite(regAddr(carrierPkg::REG_SWEEP), 32'h0077_0000, 4'b0100);
        readCheck("sweep lane 2", regAddr(carrierPkg::REG_SWEEP), 32'hDE77_BE12);
        busWrite(regAddr(carrierPkg::REG_GAIN), 32'h0000_001F, 4'b0001);
        busWrite(regAddr(carrierPkg::REG_GAIN), 32'h0000_0C00, 4'b0010);
        readCheck("gain merged", regAddr(carrierPkg::REG_GAIN), 32'h0000_0C1F);
        busWrite(regAddr(carrierPkg::REG_CTRL), 32'h0000_0007, 4'b0001);
        readCheck("ctrl bits", regAddr(carrierPkg::REG_CTRL), 32'h0000_0007);
        busWrite(outside, 32'h0000_0000, 4'hF);
        readCheck("outside readback", outside, 32'h0000_0000);
        readCheck("outside write ignored", regAddr(carrierPkg::REG_LIMIT), 32'h5522_CC44);
    endtask

    task automatic runEntry(input int i);
        stimEntry_t ent;
        int         expPulses;
        int         startPulses;
        ent         = stimTable[i];
        currentName = names[i];
        busWrite(regAddr(carrierPkg::REG_CTRL), {29'd0, ent.ctrl}, 4'hF);
        busWrite(regAddr(carrierPkg::REG_GAIN), {19'd0, ent.lagExp, 3'd0, ent.leadExp}, 4'hF);
        busWrite(regAddr(carrierPkg::REG_LIMIT), ent.limit, 4'hF);
        busWrite(regAddr(carrierPkg::REG_SWEEP), ent.sweepStep, 4'hF);
        if (!ent.ctrl[2]) begin
            dirModel = 1'b0;   // direction returns to up outside sweep
        end
        expPulses   = 0;
        startPulses = pulseCount;
        for (int k = 0; k < SAMPLE_CYCLES; k++) begin
            @(negedge clk);
            demodMode     = ent.mode;
            phase         = ent.phase;
            freq          = ent.freq;
            offsetError   = ent.offsetError;
            offsetErrorEn = ent.offEnPat[k];
            ddcSync       = ent.ddcPat[k];
            resampSync    = ent.resampPat[k];
            if (expectedStrobe(ent, k)) begin
                modelSample(ent);
                expPulses++;
            end
        end
        @(negedge clk);
        driveIdle();
        repeat (4) @(negedge clk);   // three stage pipeline drains
        if (expQ.size() != 0) begin
            errors++;
            $display("%s: %0d expected carrierFreqEn pulses never came", currentName,
                     expQ.size());
            expQ.delete();
        end
        checkValue({currentName, " pulse count"}, expPulses, pulseCount - startPulses);
    endtask

    initial begin
        reset   = 1'b1;
        addr    = 12'h000;
        din     = 32'h0000_0000;
        wrLanes = 4'b0000;
        driveIdle();
        buildTable();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        busTest();
        for (int i = 0; i < entryCount; i++) begin
            runEntry(i);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/carrierPkg.sv
verilog/loopRegs.sv
verilog/errorSelect.sv
verilog/leadGain.sv
verilog/lagGain.sv
verilog/loopFilter.sv
verilog/carrierLoop.sv
tests/carrierLoopTb.sv
